/* backing_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module backing_mem #(
    parameter int MEM_LATENCY = 3
) (
    input  logic                    cpu_intf,
    input  logic                    rst_n,
    input  cache_sys_pkg::mem_req_t req,
    output cache_sys_pkg::mem_rsp_t rsp
);
    import cache_sys_pkg::*;

    logic [31:0]            mem [word_count];
    cache_addr_u            rd_addr;
    logic [5:0]             rd_idx;
    logic [MEM_LATENCY-1:0] vld_pipe;
    logic [31:0]            dat_pipe [MEM_LATENCY];

    initial begin
        $readmemh("mem_init.hex", mem);
    end

    // Word slot relative to the start of the window
    assign rd_addr.raw = req.addr;
    assign rd_idx = 6'((rd_addr.raw - addr_base) >> 2);

    always_ff @(posedge cpu_intf or negedge rst_n) begin
        if (!rst_n) begin
            vld_pipe <= '0;
        end else begin
            vld_pipe[0] <= req.valid;
            for (int i = 1; i < MEM_LATENCY; i++) begin
                vld_pipe[i] <= vld_pipe[i-1];
            end
        end
    end

    // Data travels beside the valid bits, one stage per cycle
    always_ff @(posedge cpu_intf) begin
        dat_pipe[0] <= mem[rd_idx];
        for (int i = 1; i < MEM_LATENCY; i++) begin
            dat_pipe[i] <= dat_pipe[i-1];
        end
    end

    assign rsp.valid = vld_pipe[MEM_LATENCY-1];
    assign rsp.data = dat_pipe[MEM_LATENCY-1];

endmodule

`default_nettype wire

/* cache_sys.f */
cache_sys_pkg.sv
cpu_req_gen.sv
read_cache.sv
backing_mem.sv
cache_sys_top.sv
cache_sys_props.sv
cache_sys_tb.sv

/* cache_sys_pkg.sv */
`default_nettype none

package cache_sys_pkg;

    // Request window seen by the requester and served by the backing memory
    localparam logic [31:0] addr_base = 32'h0000_0A00;
    localparam logic [31:0] addr_top = 32'h0000_0AFF;
    localparam int word_count = 64; // Words between addr_base and addr_top

    // Field view of an address as the direct-mapped cache splits it
    typedef struct packed {
        logic [25:0] tag;
        logic [3:0]  index; // Selects one of the 16 lines
        logic [1:0]  offset; // Byte within the word, always zero here
    } cache_addr_fields_t;

    typedef union packed {
        logic [31:0]        raw;
        cache_addr_fields_t f;
    } cache_addr_u;

    // CPU side read request as a one-cycle strobe
    typedef struct packed {
        logic        valid;
        logic [31:0] addr;
    } cpu_req_t;

    // CPU side read response
    typedef struct packed {
        logic        valid;
        logic        hit; // Set when the word came straight from a cache line
        logic [31:0] addr; // Echo of the request address
        logic [31:0] data;
    } cpu_rsp_t;

    // Line fetch request to the backing memory
    typedef struct packed {
        logic        valid;
        logic [31:0] addr;
    } mem_req_t;

    // Line fetch response from the backing memory
    typedef struct packed {
        logic        valid;
        logic [31:0] data;
    } mem_rsp_t;

endpackage

`default_nettype wire

/* cache_sys_props.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_sys_props #(
    parameter int REQ_PERIOD = 10,
    parameter int MEM_LATENCY = 3
) (
    input logic                    cpu_intf,
    input logic                    rst_n,
    input logic                    run,
    input cache_sys_pkg::cpu_req_t cpu_req,
    input cache_sys_pkg::cpu_rsp_t cpu_rsp
);
    import cache_sys_pkg::*;

    int unsigned fail_count = 0; // Read by the testbench at the end of the run
    logic        run_seen;

    always_ff @(posedge cpu_intf or negedge rst_n) begin
        if (!rst_n) begin
            run_seen <= 1'b0;
        end else if (run) begin
            run_seen <= 1'b1;
        end
    end

    // Nothing may move on either side before the requester is first started
    assert property (@(posedge cpu_intf) disable iff (!rst_n)
        !run_seen |-> !cpu_req.valid && !cpu_rsp.valid)
        else begin
            fail_count++;
            $error("Strobe seen before run was ever raised");
        end

    assert property (@(posedge cpu_intf) disable iff (!rst_n)
        cpu_req.valid |=> !cpu_req.valid [*(REQ_PERIOD-1)])
        else begin
            fail_count++;
            $error("Request strobes closer than the period");
        end

    assert property (@(posedge cpu_intf) disable iff (!rst_n)
        (cpu_req.valid && run) ##1 run [*(REQ_PERIOD-1)] |=> cpu_req.valid)
        else begin
            fail_count++;
            $error("Request strobe missing after a full period");
        end

    assert property (@(posedge cpu_intf) disable iff (!rst_n)
        cpu_req.valid |-> cpu_req.addr[1:0] == 2'b00 &&
                          cpu_req.addr >= addr_base && cpu_req.addr <= addr_top)
        else begin
            fail_count++;
            $error("Request address outside the window");
        end

    // A request must not arrive before the longest response has gone out
    assert property (@(posedge cpu_intf) disable iff (!rst_n)
        cpu_req.valid |=> !cpu_req.valid [*(MEM_LATENCY+2)])
        else begin
            fail_count++;
            $error("Request issued while a read was in flight");
        end

    assert property (@(posedge cpu_intf) disable iff (!rst_n)
        cpu_rsp.valid && cpu_rsp.hit |-> $past(cpu_req.valid))
        else begin
            fail_count++;
            $error("Hit response not one cycle after its request");
        end

    assert property (@(posedge cpu_intf) disable iff (!rst_n)
        cpu_rsp.valid && !cpu_rsp.hit |-> $past(cpu_req.valid, MEM_LATENCY+2))
        else begin
            fail_count++;
            $error("Miss response at the wrong latency");
        end

endmodule

bind cache_sys_top cache_sys_props #(
    .REQ_PERIOD  (REQ_PERIOD),
    .MEM_LATENCY (MEM_LATENCY)
) props_i (
    .cpu_intf (cpu_intf),
    .rst_n    (rst_n),
    .run      (run),
    .cpu_req  (cpu_req),
    .cpu_rsp  (cpu_rsp)
);

`default_nettype wire

/* cache_sys_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_sys_tb;
    import cache_sys_pkg::*;

    localparam int REQ_PERIOD = 10;
    localparam int HIST_DEPTH = 8;
    localparam int MEM_LATENCY = 3;

    typedef struct packed {
        logic [31:0] addr;
        logic        hit; // Predicted from the shadow tag table
    } pending_t;

    logic        cpu_intf;
    logic        rst_n;
    logic        run;
    cpu_req_t    cpu_req;
    cpu_rsp_t    cpu_rsp;

    logic [31:0] mem_model [word_count];
    logic        shadow_valid [16];
    logic [25:0] shadow_tag [16];
    pending_t    pending [$];

    int unsigned pass_cnt = 0;
    int unsigned fail_cnt = 0;
    int unsigned req_seen = 0;
    int unsigned phase_hits = 0;
    int unsigned phase_misses = 0;
    int unsigned seed_val;

    cache_sys_top #(
        .REQ_PERIOD  (REQ_PERIOD),
        .HIST_DEPTH  (HIST_DEPTH),
        .MEM_LATENCY (MEM_LATENCY)
    ) dut_i (
        .cpu_intf (cpu_intf),
        .rst_n    (rst_n),
        .run      (run),
        .cpu_req  (cpu_req),
        .cpu_rsp  (cpu_rsp)
    );

    always #10 cpu_intf = ~cpu_intf;

    function automatic int unsigned total_fails();
        return fail_cnt + dut_i.props_i.fail_count;
    endfunction

    task automatic record_request(input logic [31:0] addr);
        logic [3:0]  idx;
        logic [25:0] tag;
        pending_t    entry;
        idx = addr[5:2];
        tag = addr[31:6];
        entry.addr = addr;
        entry.hit = shadow_valid[idx] && (shadow_tag[idx] == tag);
        shadow_valid[idx] = 1'b1; // A miss always leaves this tag in the line
        shadow_tag[idx] = tag;
        pending.push_back(entry);
        req_seen++;
    endtask

    task automatic check_response(input pending_t exp);
        logic [31:0] word;
        word = (exp.addr - addr_base) >> 2;
        assert (cpu_rsp.addr == exp.addr) pass_cnt++;
        else begin
            $display("Mismatch at %0t: response address %h, expected %h",
                     $time, cpu_rsp.addr, exp.addr);
            fail_cnt++;
        end
        assert (cpu_rsp.data == mem_model[word[5:0]]) pass_cnt++;
        else begin
            $display("Mismatch at %0t: data %h for address %h, expected %h",
                     $time, cpu_rsp.data, exp.addr, mem_model[word[5:0]]);
            fail_cnt++;
        end
        assert (cpu_rsp.hit == exp.hit) pass_cnt++;
        else begin
            $display("Mismatch at %0t: hit flag %0b for address %h, expected %0b",
                     $time, cpu_rsp.hit, exp.addr, exp.hit);
            fail_cnt++;
        end
        if (cpu_rsp.hit) begin
            phase_hits++;
        end else begin
            phase_misses++;
        end
    endtask

    // Outputs are sampled on the falling edge half a cycle after they settle
    always @(negedge cpu_intf) begin
        if (rst_n) begin
            if (cpu_rsp.valid) begin
                if (pending.size() == 0) begin
                    $display("Response at %0t arrived with no outstanding request", $time);
                    fail_cnt++;
                end else begin
                    check_response(pending.pop_front());
                end
            end
            if (cpu_req.valid) begin
                record_request(cpu_req.addr);
            end
        end
    end

    task automatic report_phase(input string name, input int unsigned start_fail,
                                input int unsigned reqs);
        $display("Test %s: %s (%0d requests, %0d hits, %0d misses)", name,
                 (total_fails() == start_fail) ? "PASS" : "FAIL",
                 reqs, phase_hits, phase_misses);
    endtask

    task automatic idle_phase(input string name, input int unsigned cycles);
        int unsigned start_req;
        int unsigned start_fail;
        start_req = req_seen;
        start_fail = total_fails();
        phase_hits = 0;
        phase_misses = 0;
        repeat (cycles) @(posedge cpu_intf);
        assert (req_seen == start_req && pending.size() == 0) pass_cnt++;
        else begin
            $display("Phase %s saw a request or an open read while run was low", name);
            fail_cnt++;
        end
        report_phase(name, start_fail, req_seen - start_req);
    endtask

    // Let the last request reach the monitor, then wait for its response
    task automatic drain_reads(input string name);
        int unsigned cycles;
        cycles = 0;
        while ((cycles < 2 || pending.size() != 0) && cycles < MEM_LATENCY + 10) begin
            @(posedge cpu_intf);
            cycles++;
        end
        if (pending.size() != 0) begin
            $display("Timeout in phase %s, %0d reads never answered", name, pending.size());
            fail_cnt++;
        end
    endtask

    task automatic run_phase(input string name, input bit need_hit);
        int unsigned target;
        int unsigned start_req;
        int unsigned start_fail;
        int unsigned cycles;
        int unsigned limit;
        target = 36 + ($urandom % 9);
        start_req = req_seen;
        start_fail = total_fails();
        phase_hits = 0;
        phase_misses = 0;
        limit = (target + 2) * REQ_PERIOD;
        cycles = 0;
        run <= 1'b1;
        while (req_seen - start_req < target && cycles < limit) begin
            @(posedge cpu_intf);
            cycles++;
        end
        if (req_seen - start_req < target) begin
            $display("Timeout in phase %s after %0d of %0d requests", name,
                     req_seen - start_req, target);
            fail_cnt++;
        end
        run <= 1'b0;
        drain_reads(name);
        assert (phase_misses > 0) pass_cnt++;
        else begin
            $display("Phase %s saw no cache miss", name);
            fail_cnt++;
        end
        if (need_hit) begin
            assert (phase_hits > 0) pass_cnt++;
            else begin
                $display("Phase %s saw no cache hit after the pause", name);
                fail_cnt++;
            end
        end
        report_phase(name, start_fail, req_seen - start_req);
    endtask

    initial begin
        seed_val = $urandom(62486);
        cpu_intf = 1'b0;
        rst_n = 1'b0;
        run = 1'b0;
        for (int i = 0; i < 16; i++) begin
            shadow_valid[i] = 1'b0;
            shadow_tag[i] = '0;
        end
        $readmemh("mem_init.hex", mem_model);
        repeat (10) @(posedge cpu_intf);
        rst_n <= 1'b1;
        idle_phase("reset idle", 20);
        run_phase("first run", 1'b0);
        idle_phase("pause", 30 + ($urandom % 30));
        run_phase("second run", 1'b1);
        $display("Summary: %0d passed, %0d failed", pass_cnt, total_fails());
        if (total_fails() == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* cache_sys_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_sys_top #(
    parameter int REQ_PERIOD = 10,
    parameter int HIST_DEPTH = 8,
    parameter int MEM_LATENCY = 3
) (
    input  logic                    cpu_intf,
    input  logic                    rst_n,
    input  logic                    run,
    output cache_sys_pkg::cpu_req_t cpu_req,
    output cache_sys_pkg::cpu_rsp_t cpu_rsp
);
    import cache_sys_pkg::*;

    mem_req_t mem_req;
    mem_rsp_t mem_rsp;

    cpu_req_gen #(
        .REQ_PERIOD (REQ_PERIOD),
        .HIST_DEPTH (HIST_DEPTH)
    ) req_gen_i (
        .cpu_intf (cpu_intf),
        .rst_n    (rst_n),
        .run      (run),
        .req      (cpu_req)
    );

    read_cache cache_i (
        .cpu_intf (cpu_intf),
        .rst_n    (rst_n),
        .req      (cpu_req),
        .rsp      (cpu_rsp),
        .mem_req  (mem_req),
        .mem_rsp  (mem_rsp)
    );

    backing_mem #(
        .MEM_LATENCY (MEM_LATENCY)
    ) mem_i (
        .cpu_intf (cpu_intf),
        .rst_n    (rst_n),
        .req      (mem_req),
        .rsp      (mem_rsp)
    );

endmodule

`default_nettype wire

/* cpu_req_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_req_gen #(
    parameter int REQ_PERIOD = 10,
    parameter int HIST_DEPTH = 8
) (
    input  logic                    cpu_intf,
    input  logic                    rst_n,
    input  logic                    run,
    output cache_sys_pkg::cpu_req_t req
);
    import cache_sys_pkg::*;

    localparam int CNT_W = $clog2(REQ_PERIOD);
    localparam int PTR_W = $clog2(HIST_DEPTH);
    localparam int FILL_W = $clog2(HIST_DEPTH + 1);

    logic [CNT_W-1:0]  period_cnt;
    logic              fire;
    logic [15:0]       lfsr;
    logic [5:0]        hist [HIST_DEPTH]; // Word offsets within the window
    logic [PTR_W-1:0]  wr_ptr;
    logic [FILL_W-1:0] fill;
    logic              take_new;
    logic [PTR_W-1:0]  rd_ptr;
    logic [5:0]        word_sel;
    logic              req_valid;
    logic [31:0]       req_addr;

    assign fire = run && (period_cnt == CNT_W'(REQ_PERIOD - 1));

    always_ff @(posedge cpu_intf or negedge rst_n) begin
        if (!rst_n) begin
            period_cnt <= '0;
        end else if (!run || fire) begin
            period_cnt <= '0; // Dropping run restarts the full period
        end else begin
            period_cnt <= period_cnt + 1'b1;
        end
    end

    // Fibonacci LFSR with taps 16, 14, 13 and 11, stepping every cycle
    always_ff @(posedge cpu_intf or negedge rst_n) begin
        if (!rst_n) begin
            lfsr <= 16'hACE1;
        end else begin
            lfsr <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
        end
    end

    // An empty history always forces a fresh address
    assign take_new = (fill == '0) || !lfsr[7];
    assign rd_ptr = (fill == '0) ? '0 : PTR_W'(lfsr[15:8] % fill);
    assign word_sel = take_new ? lfsr[5:0] : hist[rd_ptr];

    always_ff @(posedge cpu_intf or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            fill <= '0;
        end else if (fire && take_new) begin
            wr_ptr <= (wr_ptr == PTR_W'(HIST_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (fill != FILL_W'(HIST_DEPTH)) begin
                fill <= fill + 1'b1; // Saturates once the ring has wrapped
            end
        end
    end

    always_ff @(posedge cpu_intf) begin
        if (fire && take_new) begin
            hist[wr_ptr] <= word_sel;
        end
    end

    always_ff @(posedge cpu_intf or negedge rst_n) begin
        if (!rst_n) begin
            req_valid <= 1'b0;
        end else begin
            req_valid <= fire;
        end
    end

    always_ff @(posedge cpu_intf) begin
        if (fire) begin
            req_addr <= addr_base + {24'd0, word_sel, 2'b00};
        end
    end

    assign req.valid = req_valid;
    assign req.addr = req_addr;

endmodule

`default_nettype wire

/* mem_init.hex */
// One 32-bit data word per line, line i holds the word at byte address 0x0A00 + 4*i
F5FF0A00
F5FB0A04
F5F70A08
F5F30A0C
F5EF0A10
F5EB0A14
F5E70A18
F5E30A1C
F5DF0A20
F5DB0A24
F5D70A28
F5D30A2C
F5CF0A30
F5CB0A34
F5C70A38
F5C30A3C
F5BF0A40
F5BB0A44
F5B70A48
F5B30A4C
F5AF0A50
F5AB0A54
F5A70A58
F5A30A5C
F59F0A60
F59B0A64
F5970A68
F5930A6C
F58F0A70
F58B0A74
F5870A78
F5830A7C
F57F0A80
F57B0A84
F5770A88
F5730A8C
F56F0A90
F56B0A94
F5670A98
F5630A9C
F55F0AA0
F55B0AA4
F5570AA8
F5530AAC
F54F0AB0
F54B0AB4
F5470AB8
F5430ABC
F53F0AC0
F53B0AC4
F5370AC8
F5330ACC
F52F0AD0
F52B0AD4
F5270AD8
F5230ADC
F51F0AE0
F51B0AE4
F5170AE8
F5130AEC
F50F0AF0
F50B0AF4
F5070AF8
F5030AFC

/* read_cache.sv */
`timescale 1ns/1ps
`default_nettype none

module read_cache (
    input  logic                    cpu_intf,
    input  logic                    rst_n,
    input  cache_sys_pkg::cpu_req_t req,
    output cache_sys_pkg::cpu_rsp_t rsp,
    output cache_sys_pkg::mem_req_t mem_req,
    input  cache_sys_pkg::mem_rsp_t mem_rsp
);
    import cache_sys_pkg::*;

    localparam int LINES = 16;

    logic [LINES-1:0] line_valid;
    logic [25:0]      line_tag [LINES];
    logic [31:0]      line_data [LINES];

    cache_addr_u      req_a;
    cache_addr_u      pend_a; // Address of the miss being fetched
    logic             lookup_hit;
    logic             accept;
    logic             fill_now;
    logic             fetching;

    logic             mem_req_valid;
    logic             rsp_valid;
    logic             rsp_hit;
    logic [31:0]      rsp_addr;
    logic [31:0]      rsp_data;

    assign req_a.raw = req.addr;
    assign lookup_hit = line_valid[req_a.f.index] &&
                        (line_tag[req_a.f.index] == req_a.f.tag);

    // New requests are only taken while no fetch is open
    assign accept = req.valid && !fetching;
    assign fill_now = fetching && mem_rsp.valid;

    always_ff @(posedge cpu_intf or negedge rst_n) begin
        if (!rst_n) begin
            fetching <= 1'b0;
            mem_req_valid <= 1'b0;
        end else begin
            mem_req_valid <= accept && !lookup_hit;
            if (accept && !lookup_hit) begin
                fetching <= 1'b1;
            end else if (fill_now) begin
                fetching <= 1'b0;
            end
        end
    end

    always_ff @(posedge cpu_intf) begin
        if (accept && !lookup_hit) begin
            pend_a <= req_a;
        end
    end

    always_ff @(posedge cpu_intf or negedge rst_n) begin
        if (!rst_n) begin
            line_valid <= '0;
        end else if (fill_now) begin
            line_valid[pend_a.f.index] <= 1'b1;
        end
    end

    always_ff @(posedge cpu_intf) begin
        if (fill_now) begin
            line_tag[pend_a.f.index] <= pend_a.f.tag;
            line_data[pend_a.f.index] <= mem_rsp.data;
        end
    end

    always_ff @(posedge cpu_intf or negedge rst_n) begin
        if (!rst_n) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= (accept && lookup_hit) || fill_now;
        end
    end

    // Hit answers from the line; a fill answers with the word just fetched
    always_ff @(posedge cpu_intf) begin
        if (accept && lookup_hit) begin
            rsp_hit <= 1'b1;
            rsp_addr <= req_a.raw;
            rsp_data <= line_data[req_a.f.index];
        end else if (fill_now) begin
            rsp_hit <= 1'b0;
            rsp_addr <= pend_a.raw;
            rsp_data <= mem_rsp.data;
        end
    end

    assign mem_req.valid = mem_req_valid;
    assign mem_req.addr = pend_a.raw;

    assign rsp.valid = rsp_valid;
    assign rsp.hit = rsp_hit;
    assign rsp.addr = rsp_addr;
    assign rsp.data = rsp_data;

endmodule

`default_nettype wire
